/* design/issue_params.svh */
`ifndef ISSUE_PARAMS_SVH
`define ISSUE_PARAMS_SVH

// queue entries, kept a power of two so the pointers wrap on their own
`define ISSUE_DEPTH 8

// instructions fetched and issued per cycle
`define ISSUE_LANES 2

// integer register address width
`define REG_AW 5

`endif

/* design/issue_pkg.sv */
`include "issue_params.svh"

package issue_pkg;

  typedef struct packed {
    logic valid;
    logic alu;
    logic load;
    logic store;
    logic branch;
    logic mult;   // whole M extension, mul and div share the unit
    logic csreg;
    logic fence;
    logic wren;
    logic rden1;
    logic rden2;
  } op_class_type;

  typedef struct packed {
    logic [31:0] pc;
    logic [31:0] word;
    logic [`REG_AW-1:0] waddr;
    logic [`REG_AW-1:0] raddr1;
    logic [`REG_AW-1:0] raddr2;
    op_class_type op;
  } instr_type;

  typedef struct packed {
    logic valid;
    logic [31:0] pc;
    logic [31:0] word;
  } fetch_type;

  typedef struct packed {
    instr_type instr0;
    instr_type instr1;
    logic [1:0] count;  // instructions issued this cycle
  } issue_type;

  localparam instr_type init_instr = '{
    pc : '0,
    word : '0,
    waddr : '0,
    raddr1 : '0,
    raddr2 : '0,
    op : '0
  };

endpackage

/* design/pair_decoder.sv */
`timescale 1ns/1ps

module pair_decoder (
  input issue_pkg::fetch_type fetch0,
  input issue_pkg::fetch_type fetch1,
  output issue_pkg::instr_type dec0,
  output issue_pkg::instr_type dec1
);
  import issue_pkg::*;

  localparam logic [6:0] opc_lui = 7'b0110111;
  localparam logic [6:0] opc_auipc = 7'b0010111;
  localparam logic [6:0] opc_jal = 7'b1101111;
  localparam logic [6:0] opc_jalr = 7'b1100111;
  localparam logic [6:0] opc_branch = 7'b1100011;
  localparam logic [6:0] opc_load = 7'b0000011;
  localparam logic [6:0] opc_store = 7'b0100011;
  localparam logic [6:0] opc_op_imm = 7'b0010011;
  localparam logic [6:0] opc_op = 7'b0110011;
  localparam logic [6:0] opc_misc_mem = 7'b0001111;
  localparam logic [6:0] opc_system = 7'b1110011;

  function automatic instr_type decode(input fetch_type f);
    instr_type d;
    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    d = init_instr;
    opcode = f.word[6:0];
    funct3 = f.word[14:12];
    funct7 = f.word[31:25];
    if (f.valid) begin
      d.pc = f.pc;
      d.word = f.word;
      d.waddr = f.word[11:7];
      d.raddr1 = f.word[19:15];
      d.raddr2 = f.word[24:20];
      d.op.valid = 1'b1;
      case (opcode)
        opc_lui, opc_auipc: begin
          d.op.alu = 1'b1;
          d.op.wren = 1'b1;
        end
        opc_jal: begin
          d.op.branch = 1'b1;
          d.op.wren = 1'b1;
        end
        opc_jalr: begin
          d.op.branch = 1'b1;
          d.op.wren = 1'b1;
          d.op.rden1 = 1'b1;
        end
        opc_branch: begin
          d.op.branch = 1'b1;
          d.op.rden1 = 1'b1;
          d.op.rden2 = 1'b1;
        end
        opc_load: begin
          d.op.load = 1'b1;
          d.op.wren = 1'b1;
          d.op.rden1 = 1'b1;
        end
        opc_store: begin
          d.op.store = 1'b1;
          d.op.rden1 = 1'b1;
          d.op.rden2 = 1'b1;
        end
        opc_op_imm: begin
          d.op.alu = 1'b1;
          d.op.wren = 1'b1;
          d.op.rden1 = 1'b1;
        end
        opc_op: begin
          d.op.mult = (funct7 == 7'b0000001);
          d.op.alu = (funct7 != 7'b0000001);
          d.op.wren = 1'b1;
          d.op.rden1 = 1'b1;
          d.op.rden2 = 1'b1;
        end
        opc_misc_mem: begin
          d.op.fence = 1'b1;
        end
        opc_system: begin
          // ecall, ebreak and mret serialize the same way a fence does
          d.op.fence = (funct3 == 3'b000);
          d.op.csreg = (funct3 != 3'b000);
          d.op.wren = (funct3 != 3'b000);
          d.op.rden1 = (funct3 != 3'b000) && !funct3[2];  // immediate forms read no rs1
        end
        default: begin
          d.op.alu = 1'b0;  // unknown opcode claims no unit
        end
      endcase
      d.op.wren = d.op.wren && (d.waddr != '0);  // x0 never creates a dependency
    end
    return d;
  endfunction

  assign dec0 = decode(fetch0);
  assign dec1 = decode(fetch1);

endmodule

/* design/issue_queue.sv */
`timescale 1ns/1ps
`include "issue_params.svh"

module issue_queue (
  input logic clock,
  input logic reset,
  input logic clear,
  input issue_pkg::instr_type dec0,
  input issue_pkg::instr_type dec1,
  input logic [1:0] take,
  output issue_pkg::instr_type head0,
  output issue_pkg::instr_type head1,
  output logic [$clog2(`ISSUE_DEPTH):0] count,
  output logic stall
);
  import issue_pkg::*;

  localparam int ptr_w = $clog2(`ISSUE_DEPTH);

  instr_type mem [`ISSUE_DEPTH];
  logic [ptr_w-1:0] wptr;
  logic [ptr_w-1:0] rptr;
  logic [ptr_w:0] fill;       // entries stored in the buffer
  logic [ptr_w:0] fill_next;
  logic [1:0] nwr;            // records written this cycle
  instr_type wdata0;
  instr_type wdata1;

  always_comb begin
    wdata0 = dec0.op.valid ? dec0 : dec1;  // pack lane 1 down when lane 0 is empty
    wdata1 = dec1;
    nwr = 2'd0;
    if (!clear && !stall) begin
      nwr = 2'(dec0.op.valid) + 2'(dec1.op.valid);
    end
  end

  // the two oldest entries, taking this cycle's writes into account
  always_comb begin
    head0 = init_instr;
    head1 = init_instr;
    if (!clear) begin
      if (fill > 0) begin
        head0 = mem[rptr];
      end else if (nwr > 0) begin
        head0 = wdata0;
      end
      if (fill > 1) begin
        head1 = mem[rptr + 1'b1];
      end else if (fill == 1 && nwr > 0) begin
        head1 = wdata0;
      end else if (fill == 0 && nwr > 1) begin
        head1 = wdata1;
      end
    end
  end

  assign count = clear ? '0 : fill + (ptr_w+1)'(nwr);
  assign fill_next = count - (ptr_w+1)'(take);

  always_ff @(posedge clock) begin
    if (reset == 1'b0) begin
      wptr <= '0;
      rptr <= '0;
      fill <= '0;
      stall <= 1'b0;
    end else if (clear) begin
      wptr <= '0;
      rptr <= '0;
      fill <= '0;
      stall <= 1'b0;
    end else begin
      wptr <= wptr + ptr_w'(nwr);
      rptr <= rptr + ptr_w'(take);
      fill <= fill_next;
      stall <= fill_next > (`ISSUE_DEPTH / 2);  // leaves room for one more full fetch
    end
  end

  always_ff @(posedge clock) begin
    if (nwr > 0) begin
      mem[wptr] <= wdata0;
    end
    if (nwr > 1) begin
      mem[wptr + 1'b1] <= wdata1;
    end
  end

endmodule

/* design/pair_checker.sv */
`timescale 1ns/1ps
`include "issue_params.svh"

module pair_checker (
  input issue_pkg::instr_type head0,
  input issue_pkg::instr_type head1,
  input logic [$clog2(`ISSUE_DEPTH):0] count,
  input logic hold,
  output logic [1:0] take,
  output issue_pkg::issue_type issue
);
  import issue_pkg::*;

  localparam int count_w = $clog2(`ISSUE_DEPTH) + 1;

  logic single;     // slot 1 has to go on its own
  logic conflict;   // both want the same single-ported unit
  logic raw;
  logic [1:0] pass;

  always_comb begin
    single = head1.op.fence | head1.op.csreg;

    conflict = (head0.op.load | head0.op.store) & (head1.op.load | head1.op.store);
    conflict = conflict | (head0.op.mult & head1.op.mult);
    conflict = conflict | (head0.op.csreg & head1.op.csreg);

    raw = head0.op.wren &
      ((head1.op.rden1 & (head1.raddr1 == head0.waddr)) |
       (head1.op.rden2 & (head1.raddr2 == head0.waddr)));

    if (hold) begin
      pass = 2'd0;
    end else if (single | conflict | raw) begin
      pass = 2'd1;
    end else begin
      pass = 2'(`ISSUE_LANES);
    end

    if (count < count_w'(pass)) begin
      pass = count[1:0];  // never more than the queue holds
    end
  end

  assign take = pass;

  always_comb begin
    issue.instr0 = (pass > 0) ? head0 : init_instr;
    issue.instr1 = (pass > 1) ? head1 : init_instr;
    issue.count = pass;
  end

endmodule

/* design/issue_stage.sv */
`timescale 1ns/1ps
`include "issue_params.svh"

module issue_stage (
  input logic clock,
  input logic reset,
  input issue_pkg::fetch_type fetch0,
  input issue_pkg::fetch_type fetch1,
  input logic hold,
  input logic clear,
  output issue_pkg::issue_type issue,
  output logic stall
);
  import issue_pkg::*;

  instr_type dec0;
  instr_type dec1;
  instr_type head0;
  instr_type head1;
  logic [$clog2(`ISSUE_DEPTH):0] count;
  logic [1:0] take;

  pair_decoder pair_decoder_inst (
    .fetch0 (fetch0),
    .fetch1 (fetch1),
    .dec0   (dec0),
    .dec1   (dec1)
  );

  issue_queue issue_queue_inst (
    .clock (clock),
    .reset (reset),
    .clear (clear),
    .dec0  (dec0),
    .dec1  (dec1),
    .take  (take),
    .head0 (head0),
    .head1 (head1),
    .count (count),
    .stall (stall)
  );

  pair_checker pair_checker_inst (
    .head0 (head0),
    .head1 (head1),
    .count (count),
    .hold  (hold),
    .take  (take),
    .issue (issue)
  );

endmodule

/* test/issue_asserts.sv */
`timescale 1ns/1ps
`include "issue_params.svh"

module issue_asserts (
  input logic clock,
  input logic reset,
  input logic clear,
  input logic [1:0] take,
  input logic [1:0] nwr,
  input logic [$clog2(`ISSUE_DEPTH)-1:0] wptr,
  input logic [$clog2(`ISSUE_DEPTH)-1:0] rptr,
  input logic [$clog2(`ISSUE_DEPTH):0] fill,
  input logic [$clog2(`ISSUE_DEPTH):0] count,
  input logic stall
);

  count_in_range: assert property (@(posedge clock) disable iff (!reset)
    count <= `ISSUE_DEPTH)
    else $error("queue count above depth");

  stall_after_reset: assert property (@(posedge clock) !reset |=> !stall)
    else $error("stall high right after reset");

  // nothing written and nothing taken, so pointers and fill stay put
  idle_holds_state: assert property (@(posedge clock) disable iff (!reset)
    (!clear && nwr == 2'd0 && take == 2'd0) |=> ($stable(fill) && $stable(wptr) && $stable(rptr)))
    else $error("queue state moved with no write and no take");

endmodule

/* test/issue_tb.sv */
`timescale 1ns/1ps
`include "issue_params.svh"

module issue_tb;
  import issue_pkg::*;

  localparam int test_cycles = 60;
  localparam logic [2:0] k_alu = 3'd0;
  localparam logic [2:0] k_mult = 3'd1;
  localparam logic [2:0] k_load = 3'd2;
  localparam logic [2:0] k_store = 3'd3;
  localparam logic [2:0] k_csr = 3'd4;
  localparam logic [2:0] k_fence = 3'd5;

  typedef struct packed {
    logic [31:0] pc;
    logic [31:0] word;
    logic [2:0] kind;
    logic [4:0] rd;
    logic [4:0] rs1;
    logic [4:0] rs2;
  } entry_type;

  logic clock = 1'b0;
  logic reset;
  fetch_type fetch0;
  fetch_type fetch1;
  logic hold;
  logic clear;
  issue_type issue;
  logic stall;

  entry_type pending[$];  // waiting for fetch
  entry_type model[$];    // reference queue contents
  logic model_stall = 1'b0;
  logic saw_stall = 1'b0;
  logic [31:0] next_pc = 32'h1000;
  int checks = 0;
  int errors = 0;

  issue_stage issue_stage_inst (.*);

  bind issue_queue issue_asserts issue_asserts_inst (.*);

  always #10 clock = ~clock;

  initial begin
    #(test_cycles * 20 + 400);
    $display("watchdog expired before the tests finished");
    $display("RESULT: FAIL");
    $finish;
  end

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] expected);
    checks++;
    if (got !== expected) begin
      errors++;
      $display("[ERROR] %0t %s got %0h expected %0h", $time, name, got, expected);
    end
  endtask

  task automatic add_instr(input logic [2:0] kind, input logic [4:0] rd,
                           input logic [4:0] rs1, input logic [4:0] rs2);
    entry_type e;
    e = '{pc: next_pc, word: '0, kind: kind, rd: rd, rs1: rs1, rs2: rs2};
    case (kind)
      k_alu: e.word = {7'd0, rs2, rs1, 3'b000, rd, 7'b0110011};
      k_mult: e.word = {7'd1, rs2, rs1, 3'b000, rd, 7'b0110011};
      k_load: e.word = {12'd0, rs1, 3'b010, rd, 7'b0000011};
      k_store: e.word = {7'd0, rs2, rs1, 3'b010, 5'd0, 7'b0100011};
      k_csr: e.word = {12'h300, rs1, 3'b001, rd, 7'b1110011};  // csrrw
      default: e.word = 32'h0ff0000f;
    endcase
    next_pc += 4;
    pending.push_back(e);
  endtask

  function automatic logic writes_reg(input entry_type e);
    return (e.kind != k_store) && (e.kind != k_fence) && (e.rd != 5'd0);
  endfunction

  function automatic logic reads_reg(input entry_type e, input logic [4:0] r);
    case (e.kind)
      k_alu, k_mult, k_store: return (e.rs1 == r) || (e.rs2 == r);
      k_load, k_csr: return e.rs1 == r;
      default: return 1'b0;
    endcase
  endfunction

  // class flags an entry of each kind decodes to
  function automatic op_class_type expected_op(input entry_type e);
    op_class_type op;
    op = '0;
    op.valid = 1'b1;
    op.wren = writes_reg(e);
    case (e.kind)
      k_alu: op.alu = 1'b1;
      k_mult: op.mult = 1'b1;
      k_load: op.load = 1'b1;
      k_store: op.store = 1'b1;
      k_csr: op.csreg = 1'b1;
      default: op.fence = 1'b1;
    endcase
    op.rden1 = (e.kind != k_fence);
    op.rden2 = (e.kind inside {k_alu, k_mult, k_store});
    return op;
  endfunction

  function automatic int expected_count(input logic h);
    entry_type a;
    entry_type b;
    logic alone;
    if (h || model.size() == 0) return 0;
    if (model.size() == 1) return 1;
    a = model[0];
    b = model[1];
    alone = (b.kind == k_fence) || (b.kind == k_csr);
    alone |= (a.kind inside {k_load, k_store}) && (b.kind inside {k_load, k_store});
    alone |= (a.kind == k_mult) && (b.kind == k_mult);
    alone |= writes_reg(a) && reads_reg(b, a.rd);
    return alone ? 1 : 2;
  endfunction

  task automatic check_issued(input string slot, input instr_type got,
                              input entry_type e);
    op_class_type op;
    op = expected_op(e);
    check_value({slot, ".pc"}, got.pc, e.pc);
    check_value({slot, ".word"}, got.word, e.word);
    check_value({slot, ".op"}, got.op, op);
    if (op.wren) check_value({slot, ".waddr"}, got.waddr, e.rd);
    if (op.rden1) check_value({slot, ".raddr1"}, got.raddr1, e.rs1);
    if (op.rden2) check_value({slot, ".raddr2"}, got.raddr2, e.rs2);
  endtask

  // one clock: drive on the falling edge, check the settled issue bundle
  task automatic run_cycle(input logic h, input logic c);
    int n_in;
    int n_exp;
    @(negedge clock);
    hold = h;
    clear = c;
    fetch0 = '0;
    fetch1 = '0;
    n_in = (pending.size() > 1) ? 2 : pending.size();
    if (n_in > 0) fetch0 = {1'b1, pending[0].pc, pending[0].word};
    if (n_in > 1) fetch1 = {1'b1, pending[1].pc, pending[1].word};
    #1;
    check_value("stall", stall, model_stall);
    if (stall) saw_stall = 1'b1;
    if (c) begin
      model.delete();
      repeat (n_in) void'(pending.pop_front());  // dropped by clear
    end else if (!model_stall) begin
      repeat (n_in) model.push_back(pending.pop_front());
    end
    n_exp = c ? 0 : expected_count(h);
    check_value("issue.count", issue.count, n_exp);
    check_value("issue.instr0.valid", issue.instr0.op.valid, n_exp > 0);
    check_value("issue.instr1.valid", issue.instr1.op.valid, n_exp > 1);
    if (n_exp > 0) begin
      check_issued("issue.instr0", issue.instr0, model[0]);
    end
    if (n_exp > 1) begin
      check_issued("issue.instr1", issue.instr1, model[1]);
    end
    repeat (n_exp) void'(model.pop_front());
    model_stall = !c && (model.size() > `ISSUE_DEPTH / 2);
  endtask

  task automatic drain();
    int n;
    n = 0;
    while ((model.size() > 0 || pending.size() > 0 || model_stall) && n < 20) begin
      run_cycle(1'b0, 1'b0);
      n++;
    end
    if (model.size() > 0 || pending.size() > 0) begin
      errors++;
      $display("instructions still waiting after %0d cycles without hold", n);
    end
  endtask

  task automatic test_alu_pair();
    add_instr(k_alu, 5'd1, 5'd2, 5'd3);
    add_instr(k_alu, 5'd4, 5'd5, 5'd6);
    drain();
  endtask

  task automatic test_raw_split();
    add_instr(k_alu, 5'd0, 5'd1, 5'd2);
    add_instr(k_alu, 5'd9, 5'd0, 5'd0);  // x0 is no dependency
    add_instr(k_alu, 5'd7, 5'd1, 5'd2);
    add_instr(k_alu, 5'd8, 5'd7, 5'd3);  // reads x7, goes alone
    drain();
  endtask

  task automatic test_unit_conflicts();
    add_instr(k_load, 5'd10, 5'd1, 5'd0);
    add_instr(k_store, 5'd0, 5'd2, 5'd3);
    drain();
    add_instr(k_mult, 5'd11, 5'd1, 5'd2);
    add_instr(k_mult, 5'd12, 5'd3, 5'd4);
    drain();
    add_instr(k_alu, 5'd13, 5'd1, 5'd2);
    add_instr(k_fence, 5'd0, 5'd0, 5'd0);
    drain();
    add_instr(k_alu, 5'd14, 5'd1, 5'd2);
    add_instr(k_csr, 5'd15, 5'd5, 5'd0);
    drain();
  endtask

  task automatic test_hold_burst();
    repeat (12) begin
      add_instr(($urandom % 2) ? k_mult : k_alu, 5'($urandom), 5'($urandom), 5'($urandom));
    end
    saw_stall = 1'b0;
    repeat (8) run_cycle(1'b1, 1'b0);
    check_value("stall_seen", saw_stall, 1'b1);
    drain();
  endtask

  task automatic test_clear();
    repeat (4) add_instr(k_alu, 5'd1, 5'd2, 5'd3);
    repeat (2) run_cycle(1'b1, 1'b0);
    repeat (2) add_instr(k_alu, 5'd4, 5'd5, 5'd6);
    run_cycle(1'b0, 1'b1);
    add_instr(k_alu, 5'd20, 5'd21, 5'd22);
    add_instr(k_alu, 5'd23, 5'd24, 5'd25);
    drain();
  endtask

  initial begin
    void'($urandom(50));
    reset = 1'b0;
    fetch0 = '0;
    fetch1 = '0;
    hold = 1'b0;
    clear = 1'b0;
    repeat (3) @(posedge clock);
    @(negedge clock);
    reset = 1'b1;
    test_alu_pair();
    test_raw_split();
    test_unit_conflicts();
    test_hold_burst();
    test_clear();
    $display("checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

endmodule

/* build.f */
+incdir+design
design/issue_pkg.sv
design/pair_decoder.sv
design/issue_queue.sv
design/pair_checker.sv
design/issue_stage.sv
test/issue_asserts.sv
test/issue_tb.sv

/* Bender.yml */
package:
  name: issue_stage

sources:
  - include_dirs:
      - design
    files:
      - design/issue_pkg.sv
      - design/pair_decoder.sv
      - design/issue_queue.sv
      - design/pair_checker.sv
      - design/issue_stage.sv
  - target: test
    include_dirs:
      - design
    files:
      - test/issue_asserts.sv
      - test/issue_tb.sv
